/* design/id_pkg.sv */
package id_pkg;

	// RV32I major opcodes
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'h03,
		OPC_OP_IMM = 7'h13,
		OPC_AUIPC  = 7'h17,
		OPC_STORE  = 7'h23,
		OPC_OP     = 7'h33,
		OPC_LUI    = 7'h37,
		OPC_BRANCH = 7'h63,
		OPC_JALR   = 7'h67,
		OPC_JAL    = 7'h6f
	} opcode_e;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
		ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
	} alu_op_e;

	typedef enum logic [1:0] {
		LSU_WORD = 2'd0,
		LSU_HALF = 2'd1,
		LSU_BYTE = 2'd2
	} lsu_size_e;

	// code 1 is not used
	typedef enum logic [1:0] {
		OP_A_RS1  = 2'd0,
		OP_A_PC   = 2'd2,
		OP_A_ZERO = 2'd3
	} op_a_sel_e;

	typedef enum logic {
		OP_B_RS2 = 1'b0,
		OP_B_IMM = 1'b1
	} op_b_sel_e;

	typedef enum logic [2:0] {
		IMM_I    = 3'd0,
		IMM_S    = 3'd1,
		IMM_B    = 3'd2,
		IMM_U    = 3'd3,
		IMM_J    = 3'd4,
		IMM_FOUR = 3'd5
	} imm_sel_e;

	typedef enum logic [1:0] {
		CLASS_PLAIN, CLASS_MEM, CLASS_BRANCH, CLASS_JUMP
	} instr_class_e;

	// one view per instruction format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic       imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic       imm11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
		struct packed {
			logic       imm20;
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} instr_u;

	typedef struct packed {
		instr_class_e instr_class;
		alu_op_e      alu_op;
		op_a_sel_e    op_a_sel;
		op_b_sel_e    op_b_sel;
		imm_sel_e     imm_sel;
		logic         lsu_we;
		lsu_size_e    lsu_size;
		logic         lsu_sign_ext;
		logic         rf_we;
	} dec_ctrl_t;

	typedef struct packed {
		alu_op_e     operator;
		logic [31:0] operand_a;
		logic [31:0] operand_b;
	} alu_req_t;

	typedef struct packed {
		logic        req;
		logic        we;
		lsu_size_e   size;
		logic        sign_ext;
		logic [31:0] wdata;
	} lsu_req_t;

endpackage

/* design/id_decoder.sv */
`timescale 1ns/1ns

module id_decoder import id_pkg::*; #(
	parameter bit rv32e = 1'b0
) (
	input  instr_u    instr_i,
	input  logic      first_cycle_i,
	output dec_ctrl_t ctrl_o,
	output logic [4:0] raddr_a_o,
	output logic [4:0] raddr_b_o,
	output logic [4:0] waddr_o,
	output logic      illegal_o
);

	logic    illegal_op;
	logic    rs1_used;
	logic    rs2_used;
	logic    reg_illegal;
	alu_op_e cmp_op;

	// register fields sit at the same place in every format
	assign raddr_a_o = instr_i.r.rs1;
	assign raddr_b_o = instr_i.r.rs2;
	assign waddr_o   = instr_i.r.rd;

	always_comb begin
		ctrl_o.instr_class  = CLASS_PLAIN;
		ctrl_o.alu_op       = ALU_ADD;
		ctrl_o.op_a_sel     = OP_A_RS1;
		ctrl_o.op_b_sel     = OP_B_IMM;
		ctrl_o.imm_sel      = IMM_I;
		ctrl_o.lsu_we       = 1'b0;
		ctrl_o.lsu_size     = LSU_WORD;
		ctrl_o.lsu_sign_ext = 1'b0;
		ctrl_o.rf_we        = 1'b0;
		illegal_op = 1'b0;
		rs1_used   = 1'b0;
		rs2_used   = 1'b0;
		cmp_op     = ALU_EQ;

		case (instr_i.r.opcode)
			OPC_OP: begin
				ctrl_o.op_b_sel = OP_B_RS2;
				ctrl_o.rf_we = 1'b1;
				rs1_used = 1'b1;
				rs2_used = 1'b1;
				case ({instr_i.r.funct7, instr_i.r.funct3})
					{7'h00, 3'b000}: ctrl_o.alu_op = ALU_ADD;
					{7'h20, 3'b000}: ctrl_o.alu_op = ALU_SUB;
					{7'h00, 3'b001}: ctrl_o.alu_op = ALU_SLL;
					{7'h00, 3'b010}: ctrl_o.alu_op = ALU_SLT;
					{7'h00, 3'b011}: ctrl_o.alu_op = ALU_SLTU;
					{7'h00, 3'b100}: ctrl_o.alu_op = ALU_XOR;
					{7'h00, 3'b101}: ctrl_o.alu_op = ALU_SRL;
					{7'h20, 3'b101}: ctrl_o.alu_op = ALU_SRA;
					{7'h00, 3'b110}: ctrl_o.alu_op = ALU_OR;
					{7'h00, 3'b111}: ctrl_o.alu_op = ALU_AND;
					default: illegal_op = 1'b1;
				endcase
			end
			OPC_OP_IMM: begin
				ctrl_o.rf_we = 1'b1;
				rs1_used = 1'b1;
				case (instr_i.i.funct3)
					3'b000: ctrl_o.alu_op = ALU_ADD;
					3'b010: ctrl_o.alu_op = ALU_SLT;
					3'b011: ctrl_o.alu_op = ALU_SLTU;
					3'b100: ctrl_o.alu_op = ALU_XOR;
					3'b110: ctrl_o.alu_op = ALU_OR;
					3'b111: ctrl_o.alu_op = ALU_AND;
					3'b001: begin
						ctrl_o.alu_op = ALU_SLL;
						illegal_op = (instr_i.r.funct7 != 7'h00);
					end
					default: begin
						// shift right, funct7 picks logical or arithmetic
						ctrl_o.alu_op = (instr_i.r.funct7 == 7'h20) ? ALU_SRA : ALU_SRL;
						illegal_op = (instr_i.r.funct7 != 7'h00) && (instr_i.r.funct7 != 7'h20);
					end
				endcase
			end
			OPC_LUI, OPC_AUIPC: begin
				ctrl_o.op_a_sel = (instr_i.u.opcode == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
				ctrl_o.imm_sel = IMM_U;
				ctrl_o.rf_we = 1'b1;
			end
			OPC_LOAD: begin
				ctrl_o.instr_class = CLASS_MEM;
				ctrl_o.rf_we = 1'b1;
				ctrl_o.lsu_sign_ext = ~instr_i.i.funct3[2];
				rs1_used = 1'b1;
				case (instr_i.i.funct3)
					3'b000, 3'b100: ctrl_o.lsu_size = LSU_BYTE;
					3'b001, 3'b101: ctrl_o.lsu_size = LSU_HALF;
					3'b010: ctrl_o.lsu_size = LSU_WORD;
					default: illegal_op = 1'b1;
				endcase
			end
			OPC_STORE: begin
				ctrl_o.instr_class = CLASS_MEM;
				ctrl_o.imm_sel = IMM_S;
				ctrl_o.lsu_we = 1'b1;
				rs1_used = 1'b1;
				rs2_used = 1'b1;
				case (instr_i.s.funct3)
					3'b000: ctrl_o.lsu_size = LSU_BYTE;
					3'b001: ctrl_o.lsu_size = LSU_HALF;
					3'b010: ctrl_o.lsu_size = LSU_WORD;
					default: illegal_op = 1'b1;
				endcase
			end
			OPC_BRANCH: begin
				ctrl_o.instr_class = CLASS_BRANCH;
				rs1_used = 1'b1;
				rs2_used = 1'b1;
				case (instr_i.b.funct3)
					3'b000: cmp_op = ALU_EQ;
					3'b001: cmp_op = ALU_NE;
					3'b100: cmp_op = ALU_LT;
					3'b101: cmp_op = ALU_GE;
					3'b110: cmp_op = ALU_LTU;
					3'b111: cmp_op = ALU_GEU;
					default: illegal_op = 1'b1;
				endcase
				// compare first, then the target pc + imm
				if (first_cycle_i) begin
					ctrl_o.op_b_sel = OP_B_RS2;
					ctrl_o.alu_op = cmp_op;
				end else begin
					ctrl_o.op_a_sel = OP_A_PC;
					ctrl_o.imm_sel = IMM_B;
				end
			end
			OPC_JAL, OPC_JALR: begin
				ctrl_o.instr_class = CLASS_JUMP;
				ctrl_o.rf_we = 1'b1;
				if (instr_i.j.opcode == OPC_JALR) begin
					rs1_used = 1'b1;
					illegal_op = (instr_i.i.funct3 != 3'b000);
				end
				// target first, link address in the second cycle
				if (first_cycle_i) begin
					ctrl_o.op_a_sel = (instr_i.j.opcode == OPC_JAL) ? OP_A_PC : OP_A_RS1;
					ctrl_o.imm_sel = (instr_i.j.opcode == OPC_JAL) ? IMM_J : IMM_I;
				end else begin
					ctrl_o.op_a_sel = OP_A_PC;
					ctrl_o.imm_sel = IMM_FOUR;
				end
			end
			default: illegal_op = 1'b1;
		endcase
	end

	// only x0..x15 exist in the embedded variant
	assign reg_illegal = rv32e && ((rs1_used && instr_i.r.rs1[4]) ||
		(rs2_used && instr_i.r.rs2[4]) || (ctrl_o.rf_we && instr_i.r.rd[4]));

	assign illegal_o = illegal_op | reg_illegal;

endmodule

/* design/id_operand_mux.sv */
`timescale 1ns/1ns

module id_operand_mux import id_pkg::*; (
	input  instr_u      instr_i,
	input  dec_ctrl_t   ctrl_i,
	input  logic [31:0] pc_i,
	input  logic [31:0] rs1_rdata_i,
	input  logic [31:0] rs2_rdata_i,
	output logic [31:0] operand_a_o,
	output logic [31:0] operand_b_o,
	output logic [31:0] wdata_o
);

	logic [31:0] imm_i_type;
	logic [31:0] imm_s_type;
	logic [31:0] imm_b_type;
	logic [31:0] imm_u_type;
	logic [31:0] imm_j_type;
	logic [31:0] imm;

	// sign-extended immediates
	assign imm_i_type = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
	assign imm_s_type = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
	assign imm_b_type = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
		instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
	assign imm_u_type = {instr_i.u.imm, 12'h000};
	assign imm_j_type = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
		instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};

	always_comb begin
		case (ctrl_i.imm_sel)
			IMM_I:   imm = imm_i_type;
			IMM_S:   imm = imm_s_type;
			IMM_B:   imm = imm_b_type;
			IMM_U:   imm = imm_u_type;
			IMM_J:   imm = imm_j_type;
			default: imm = 32'd4;
		endcase
	end

	always_comb begin
		case (ctrl_i.op_a_sel)
			OP_A_RS1: operand_a_o = rs1_rdata_i;
			OP_A_PC:  operand_a_o = pc_i;
			default:  operand_a_o = '0;
		endcase
	end

	assign operand_b_o = (ctrl_i.op_b_sel == OP_B_IMM) ? imm : rs2_rdata_i;

	// store data always comes from rs2
	assign wdata_o = rs2_rdata_i;

endmodule

/* design/id_sequencer.sv */
`timescale 1ns/1ns

module id_sequencer import id_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_ni,
	input  logic      instr_valid_i,
	input  logic      illegal_i,
	input  logic      branch_decision_i,
	input  logic      lsu_resp_valid_i,
	input  dec_ctrl_t ctrl_i,
	output logic      first_cycle_o,
	output logic      lsu_req_o,
	output logic      pc_set_o,
	output logic      rf_we_o,
	output logic      instr_done_o
);

	localparam logic ST_FIRST = 1'b0;
	localparam logic ST_WAIT  = 1'b1;

	logic state_q, state_d;
	logic stall;
	logic branch_set_d, branch_set_q;
	logic jump_set;
	logic set_done_q;
	instr_class_e cls;

	// illegal instructions are treated as plain ones
	assign cls = illegal_i ? CLASS_PLAIN : ctrl_i.instr_class;

	assign first_cycle_o = instr_valid_i & (state_q == ST_FIRST);

	always_comb begin
		state_d = state_q;
		stall = 1'b0;
		branch_set_d = 1'b0;
		jump_set = 1'b0;
		lsu_req_o = 1'b0;
		if (instr_valid_i) begin
			if (state_q == ST_FIRST) begin
				case (cls)
					CLASS_MEM: begin
						lsu_req_o = 1'b1;
						stall = 1'b1;
						state_d = ST_WAIT;
					end
					CLASS_BRANCH: begin
						// not taken completes right away
						stall = branch_decision_i;
						branch_set_d = branch_decision_i;
						state_d = branch_decision_i ? ST_WAIT : ST_FIRST;
					end
					CLASS_JUMP: begin
						stall = 1'b1;
						jump_set = 1'b1;
						state_d = ST_WAIT;
					end
					default: state_d = ST_FIRST;
				endcase
			end else if ((cls != CLASS_MEM) || lsu_resp_valid_i) begin
				state_d = ST_FIRST;
			end else begin
				stall = 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= ST_FIRST;
			branch_set_q <= 1'b0;
			set_done_q <= 1'b0;
		end else begin
			if (instr_valid_i) begin
				state_q <= state_d;
			end
			branch_set_q <= branch_set_d;
			set_done_q <= (branch_set_q | jump_set | set_done_q) & ~instr_done_o;
		end
	end

	// one pc set per instruction
	assign pc_set_o = (branch_set_q | jump_set) & ~set_done_q;

	assign instr_done_o = instr_valid_i & ~stall;
	assign rf_we_o = instr_done_o & ctrl_i.rf_we & ~illegal_i;

endmodule

/* design/id_stage.sv */
`timescale 1ns/1ns

module id_stage import id_pkg::*; #(
	parameter bit rv32e = 1'b0
) (
	input  logic        clk_i,
	input  logic        rst_ni,
	input  logic        instr_valid_i,
	input  logic [31:0] instr_rdata_i,
	input  logic [31:0] pc_id_i,
	input  logic        branch_decision_i,
	input  logic        lsu_resp_valid_i,
	input  logic [31:0] rf_rdata_a_i,
	input  logic [31:0] rf_rdata_b_i,
	output logic [4:0]  rf_raddr_a_o,
	output logic [4:0]  rf_raddr_b_o,
	output logic [4:0]  rf_waddr_o,
	output logic        rf_we_o,
	output logic        illegal_insn_o,
	output logic        pc_set_o,
	output logic        instr_done_o,
	output alu_req_t    alu_req_o,
	output lsu_req_t    lsu_req_o
);

	instr_u      instr;
	dec_ctrl_t   ctrl;
	logic        illegal;
	logic        first_cycle;
	logic        lsu_req;
	logic [31:0] operand_a;
	logic [31:0] operand_b;
	logic [31:0] lsu_wdata;

	assign instr = instr_u'(instr_rdata_i);

	id_decoder #(
		.rv32e(rv32e)
	) u_decoder (
		.instr_i      (instr),
		.first_cycle_i(first_cycle),
		.ctrl_o       (ctrl),
		.raddr_a_o    (rf_raddr_a_o),
		.raddr_b_o    (rf_raddr_b_o),
		.waddr_o      (rf_waddr_o),
		.illegal_o    (illegal)
	);

	id_operand_mux u_operand_mux (
		.instr_i    (instr),
		.ctrl_i     (ctrl),
		.pc_i       (pc_id_i),
		.rs1_rdata_i(rf_rdata_a_i),
		.rs2_rdata_i(rf_rdata_b_i),
		.operand_a_o(operand_a),
		.operand_b_o(operand_b),
		.wdata_o    (lsu_wdata)
	);

	id_sequencer u_sequencer (
		.clk_i            (clk_i),
		.rst_ni           (rst_ni),
		.instr_valid_i    (instr_valid_i),
		.illegal_i        (illegal),
		.branch_decision_i(branch_decision_i),
		.lsu_resp_valid_i (lsu_resp_valid_i),
		.ctrl_i           (ctrl),
		.first_cycle_o    (first_cycle),
		.lsu_req_o        (lsu_req),
		.pc_set_o         (pc_set_o),
		.rf_we_o          (rf_we_o),
		.instr_done_o     (instr_done_o)
	);

	assign illegal_insn_o = instr_valid_i & illegal;

	assign alu_req_o = '{operator: ctrl.alu_op, operand_a: operand_a, operand_b: operand_b};
	assign lsu_req_o = '{req: lsu_req, we: ctrl.lsu_we, size: ctrl.lsu_size,
		sign_ext: ctrl.lsu_sign_ext, wdata: lsu_wdata};

endmodule

/* bench/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// instruction encoders, one per format
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
	return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
endfunction

// bit 0 of a branch offset is not encoded
function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
	input logic [6:0] opc);
	return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
endfunction

// sign extends the low bits of val
function automatic logic [31:0] sext(input logic [31:0] val, input int bits);
	logic [31:0] m;
	m = 32'h1 << (bits - 1);
	return ((val & ((m << 1) - 1)) ^ m) - m;
endfunction

// RV32I arithmetic table, alt is the funct7 bit 5 variant
function automatic alu_op_e alu_ref(input logic [2:0] f3, input logic alt);
	case (f3)
		3'b000:  return alt ? ALU_SUB : ALU_ADD;
		3'b001:  return ALU_SLL;
		3'b010:  return ALU_SLT;
		3'b011:  return ALU_SLTU;
		3'b100:  return ALU_XOR;
		3'b101:  return alt ? ALU_SRA : ALU_SRL;
		3'b110:  return ALU_OR;
		default: return ALU_AND;
	endcase
endfunction

function automatic alu_op_e cmp_ref(input logic [2:0] f3);
	case (f3)
		3'b000:  return ALU_EQ;
		3'b001:  return ALU_NE;
		3'b100:  return ALU_LT;
		3'b101:  return ALU_GE;
		3'b110:  return ALU_LTU;
		default: return ALU_GEU;
	endcase
endfunction

`endif

/* bench/tb_id_stage.sv */
`timescale 1ns/1ns

module tb_id_stage import id_pkg::*; ();

	`include "tb_model.svh"

	localparam int N_TESTS = 6;
	localparam int N_ITER = 24;
	localparam int MAX_DELAY = 6;
	localparam int WATCHDOG_NS = (N_TESTS * N_ITER + 10) * (MAX_DELAY + 4) * 4;

	logic        clk_i;
	logic        rst_ni;
	logic        instr_valid_i;
	logic        branch_decision_i;
	logic        lsu_resp_valid_i;
	logic [31:0] instr_rdata_i;
	logic [31:0] pc_id_i;
	logic [31:0] rf_rdata_a_i;
	logic [31:0] rf_rdata_b_i;
	logic [4:0]  rf_raddr_a_o;
	logic [4:0]  rf_raddr_b_o;
	logic [4:0]  rf_waddr_o;
	logic        rf_we_o;
	logic        illegal_insn_o;
	logic        pc_set_o;
	logic        instr_done_o;
	alu_req_t    alu_req_o;
	lsu_req_t    lsu_req_o;

	// expected outputs for the current cycle
	logic        exp_done;
	logic        exp_pc_set;
	logic        exp_rf_we;
	logic        exp_req;
	logic        exp_illegal;
	logic        chk_alu;
	logic        chk_lsu;
	// bit 2 read port a, bit 1 read port b, bit 0 write port
	logic [2:0]  chk_reg;
	logic [4:0]  exp_ra;
	logic [4:0]  exp_rb;
	logic [4:0]  exp_wa;
	alu_req_t    exp_alu;
	lsu_req_t    exp_lsu;
	int          err_cnt;
	int          tests_run;
	int          tests_failed;
	logic [31:0] rng;

	id_stage #(
		.rv32e(1'b1)
	) dut (
		.clk_i            (clk_i),
		.rst_ni           (rst_ni),
		.instr_valid_i    (instr_valid_i),
		.instr_rdata_i    (instr_rdata_i),
		.pc_id_i          (pc_id_i),
		.branch_decision_i(branch_decision_i),
		.lsu_resp_valid_i (lsu_resp_valid_i),
		.rf_rdata_a_i     (rf_rdata_a_i),
		.rf_rdata_b_i     (rf_rdata_b_i),
		.rf_raddr_a_o     (rf_raddr_a_o),
		.rf_raddr_b_o     (rf_raddr_b_o),
		.rf_waddr_o       (rf_waddr_o),
		.rf_we_o          (rf_we_o),
		.illegal_insn_o   (illegal_insn_o),
		.pc_set_o         (pc_set_o),
		.instr_done_o     (instr_done_o),
		.alu_req_o        (alu_req_o),
		.lsu_req_o        (lsu_req_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	task automatic flag_error(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		err_cnt++;
	endtask

	a_done: assert property (@(posedge clk_i) disable iff (!rst_ni) instr_done_o == exp_done)
		else flag_error("instr_done_o differs from the expected value");
	a_pc_set: assert property (@(posedge clk_i) disable iff (!rst_ni) pc_set_o == exp_pc_set)
		else flag_error("pc_set_o differs from the expected value");
	a_rf_we: assert property (@(posedge clk_i) disable iff (!rst_ni) rf_we_o == exp_rf_we)
		else flag_error("rf_we_o differs from the expected value");
	a_req: assert property (@(posedge clk_i) disable iff (!rst_ni) lsu_req_o.req == exp_req)
		else flag_error("lsu request differs from the expected value");
	a_illegal: assert property (@(posedge clk_i) disable iff (!rst_ni)
		illegal_insn_o == exp_illegal)
		else flag_error("illegal_insn_o differs from the expected value");
	a_alu: assert property (@(posedge clk_i) disable iff (!rst_ni) chk_alu |-> alu_req_o == exp_alu)
		else flag_error("ALU operator or operands wrong");
	a_lsu: assert property (@(posedge clk_i) disable iff (!rst_ni) chk_lsu |->
		{lsu_req_o.we, lsu_req_o.size, lsu_req_o.sign_ext, lsu_req_o.wdata} ==
		{exp_lsu.we, exp_lsu.size, exp_lsu.sign_ext, exp_lsu.wdata})
		else flag_error("LSU we, size, sign_ext or wdata wrong");
	a_raddr_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
		chk_reg[2] |-> rf_raddr_a_o == exp_ra)
		else flag_error("rf_raddr_a_o wrong");
	a_raddr_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
		chk_reg[1] |-> rf_raddr_b_o == exp_rb)
		else flag_error("rf_raddr_b_o wrong");
	a_waddr: assert property (@(posedge clk_i) disable iff (!rst_ni)
		chk_reg[0] |-> rf_waddr_o == exp_wa)
		else flag_error("rf_waddr_o wrong");

	// xorshift32
	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic step();
		@(posedge clk_i);
		#1;
	endtask

	task automatic clear_expect();
		exp_done = 1'b0;
		exp_pc_set = 1'b0;
		exp_rf_we = 1'b0;
		exp_req = 1'b0;
		exp_illegal = 1'b0;
		chk_alu = 1'b0;
		chk_lsu = 1'b0;
		chk_reg = 3'b000;
		exp_ra = '0;
		exp_rb = '0;
		exp_wa = '0;
		exp_alu = '0;
		exp_lsu = '0;
	endtask

	task automatic set_alu(input alu_op_e op, input logic [31:0] a, input logic [31:0] b);
		chk_alu = 1'b1;
		exp_alu.operator = op;
		exp_alu.operand_a = a;
		exp_alu.operand_b = b;
	endtask

	task automatic set_regs(input logic [2:0] mask, input logic [4:0] ra, input logic [4:0] rb,
		input logic [4:0] wa);
		chk_reg = mask;
		exp_ra = ra;
		exp_rb = rb;
		exp_wa = wa;
	endtask

	// presents a word with fresh pc and register data
	task automatic issue(input logic [31:0] word);
		instr_valid_i = 1'b1;
		instr_rdata_i = word;
		pc_id_i = next_rand() & 32'hffff_fffc;
		rf_rdata_a_i = next_rand();
		rf_rdata_b_i = next_rand();
		branch_decision_i = 1'b0;
		lsu_resp_valid_i = 1'b0;
		clear_expect();
	endtask

	task automatic idle();
		instr_valid_i = 1'b0;
		branch_decision_i = 1'b0;
		lsu_resp_valid_i = 1'b0;
		clear_expect();
		step();
	endtask

	task automatic alu_test();
		logic [31:0] r;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [11:0] imm;
		logic        use_imm;
		logic        alt;
		repeat (N_ITER) begin
			r = next_rand();
			rs1 = {1'b0, r[3:0]};
			rs2 = {1'b0, r[7:4]};
			rd = {1'b0, r[11:8]};
			f3 = r[14:12];
			use_imm = r[15];
			alt = r[16] && ((f3 == 3'b101) || (!use_imm && f3 == 3'b000));
			imm = r[31:20];
			// immediate shifts carry funct7 in the upper immediate bits
			if (use_imm && (f3 == 3'b001 || f3 == 3'b101))
				imm = {1'b0, alt, 5'b0, rs2};
			if (use_imm)
				issue(enc_i(imm, rs1, f3, rd, 7'h13));
			else
				issue(enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd, 7'h33));
			set_alu(alu_ref(f3, alt), rf_rdata_a_i, use_imm ? sext(imm, 12) : rf_rdata_b_i);
			set_regs(use_imm ? 3'b101 : 3'b111, rs1, rs2, rd);
			exp_done = 1'b1;
			exp_rf_we = 1'b1;
			step();
		end
	endtask

	task automatic upper_test();
		logic [31:0] r;
		logic        is_lui;
		repeat (N_ITER) begin
			r = next_rand();
			is_lui = r[12];
			issue(enc_u(r[31:12], {1'b0, r[3:0]}, is_lui ? 7'h37 : 7'h17));
			set_alu(ALU_ADD, is_lui ? 32'd0 : pc_id_i, {r[31:12], 12'h000});
			set_regs(3'b001, '0, '0, {1'b0, r[3:0]});
			exp_done = 1'b1;
			exp_rf_we = 1'b1;
			step();
		end
	endtask

	task automatic mem_test();
		logic [31:0] r;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic        is_store;
		int          delay;
		int          k;
		repeat (N_ITER) begin
			r = next_rand();
			rs1 = {1'b0, r[3:0]};
			rs2 = {1'b0, r[7:4]};
			is_store = r[8];
			delay = 1 + (next_rand() % MAX_DELAY);
			// loads skip funct3 3 and stores only use 0..2
			if (is_store)
				f3 = r[11:9] % 3;
			else
				f3 = (r[11:9] % 5 < 3) ? r[11:9] % 5 : r[11:9] % 5 + 1;
			if (is_store)
				issue(enc_s(r[31:20], rs2, rs1, f3));
			else
				issue(enc_i(r[31:20], rs1, f3, rs2, 7'h03));
			set_alu(ALU_ADD, rf_rdata_a_i, sext(r[31:20], 12));
			set_regs(is_store ? 3'b110 : 3'b101, rs1, rs2, rs2);
			chk_lsu = 1'b1;
			exp_lsu.we = is_store;
			exp_lsu.size = (f3[1:0] == 2'b00) ? LSU_BYTE : (f3[1:0] == 2'b01) ? LSU_HALF : LSU_WORD;
			exp_lsu.sign_ext = !is_store && !f3[2];
			exp_lsu.wdata = rf_rdata_b_i;
			exp_req = 1'b1;
			step();
			exp_req = 1'b0;
			for (k = 1; k <= delay; k++) begin
				lsu_resp_valid_i = (k == delay);
				exp_done = (k == delay);
				exp_rf_we = !is_store && (k == delay);
				step();
			end
		end
	endtask

	task automatic branch_test();
		logic [31:0] r;
		logic [12:0] imm;
		logic [2:0]  f3;
		logic        taken;
		repeat (N_ITER) begin
			r = next_rand();
			imm = r[31:19] & 13'h1ffe;
			f3 = (r[10:8] % 6 < 2) ? r[10:8] % 6 : r[10:8] % 6 + 2;
			taken = r[11];
			issue(enc_b(imm, {1'b0, r[7:4]}, {1'b0, r[3:0]}, f3));
			branch_decision_i = taken;
			set_alu(cmp_ref(f3), rf_rdata_a_i, rf_rdata_b_i);
			set_regs(3'b110, {1'b0, r[3:0]}, {1'b0, r[7:4]}, '0);
			exp_done = !taken;
			step();
			if (taken) begin
				branch_decision_i = 1'b0;
				set_alu(ALU_ADD, pc_id_i, sext(imm, 13));
				exp_done = 1'b1;
				exp_pc_set = 1'b1;
				step();
			end
		end
	endtask

	task automatic jump_test();
		logic [31:0] r;
		logic [20:0] jimm;
		logic [4:0]  rd;
		logic        is_jal;
		repeat (N_ITER) begin
			r = next_rand();
			jimm = r[31:11] & 21'h1ffffe;
			rd = {1'b0, r[3:0]};
			is_jal = r[8];
			if (is_jal)
				issue(enc_j(jimm, rd));
			else
				issue(enc_i(r[31:20], {1'b0, r[7:4]}, 3'b000, rd, 7'h67));
			if (is_jal)
				set_alu(ALU_ADD, pc_id_i, sext(jimm, 21));
			else
				set_alu(ALU_ADD, rf_rdata_a_i, sext(r[31:20], 12));
			set_regs(is_jal ? 3'b001 : 3'b101, {1'b0, r[7:4]}, '0, rd);
			exp_pc_set = 1'b1;
			step();
			// link address
			set_alu(ALU_ADD, pc_id_i, 32'd4);
			exp_pc_set = 1'b0;
			exp_done = 1'b1;
			exp_rf_we = 1'b1;
			step();
		end
	endtask

	task automatic illegal_test();
		logic [31:0] r;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [6:0]  f7;
		logic [31:0] word;
		repeat (N_ITER) begin
			r = next_rand();
			rs1 = {1'b0, r[3:0]};
			rs2 = {1'b0, r[7:4]};
			rd = {1'b0, r[11:8]};
			f7 = r[31:25];
			case (r[13:12])
				2'd0: word = {r[31:7], r[14] ? 7'h73 : 7'h0b};
				2'd1: begin
					if (f7 == 7'h00 || f7 == 7'h20)
						f7 = 7'h01;
					word = enc_r(f7, rs2, rs1, r[16:14], rd, 7'h33);
				end
				2'd2: begin
					// one register outside x0..x15
					if (r[14])
						rs1[4] = 1'b1;
					else if (r[15])
						rs2[4] = 1'b1;
					else
						rd[4] = 1'b1;
					word = enc_r(7'h00, rs2, rs1, 3'b000, rd, 7'h33);
				end
				default: begin
					// undefined funct3 on load, store, branch and jalr
					case (r[15:14])
						2'd0: word = enc_i(r[31:20], rs1, 3'b011, rd, 7'h03);
						2'd1: word = enc_s(r[31:20], rs2, rs1, 3'b011);
						2'd2: word = enc_b({r[31:20], 1'b0}, rs2, rs1, 3'b010);
						default: word = enc_i(r[31:20], rs1, 3'b001, rd, 7'h67);
					endcase
				end
			endcase
			issue(word);
			// a taken decision must not redirect an illegal branch
			branch_decision_i = 1'b1;
			exp_illegal = 1'b1;
			exp_done = 1'b1;
			step();
		end
	endtask

	task automatic close_test(input string name, input int errs_before);
		idle();
		tests_run++;
		if (err_cnt == errs_before) begin
			$display("test %0s: ok", name);
		end else begin
			tests_failed++;
			$display("test %0s: %0d errors", name, err_cnt - errs_before);
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("the run timed out before all tests finished");
		$display("Regression failed");
		$finish;
	end

	initial begin
		int errs;
		rst_ni = 1'b0;
		instr_valid_i = 1'b0;
		instr_rdata_i = '0;
		pc_id_i = '0;
		branch_decision_i = 1'b0;
		lsu_resp_valid_i = 1'b0;
		rf_rdata_a_i = '0;
		rf_rdata_b_i = '0;
		err_cnt = 0;
		tests_run = 0;
		tests_failed = 0;
		rng = 32'h1a18ac01;
		clear_expect();
		repeat (4) @(posedge clk_i);
		#1;
		rst_ni = 1'b1;
		step();
		errs = err_cnt;
		alu_test();
		close_test("alu", errs);
		errs = err_cnt;
		upper_test();
		close_test("lui_auipc", errs);
		errs = err_cnt;
		mem_test();
		close_test("load_store", errs);
		errs = err_cnt;
		branch_test();
		close_test("branch", errs);
		errs = err_cnt;
		jump_test();
		close_test("jump", errs);
		errs = err_cnt;
		illegal_test();
		close_test("illegal", errs);
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* list.f */
+incdir+bench
design/id_pkg.sv
design/id_decoder.sv
design/id_operand_mux.sv
design/id_sequencer.sv
design/id_stage.sv
bench/tb_id_stage.sv
